// File: hdl/mcu_trap_pkg.sv
package mcu_trap_pkg;

    // ========================================================================
    // widths
    // ========================================================================
    localparam int XLEN        = 32;
    localparam int PLIC_ADDR_W = 24;
    localparam int CSR_ADDR_W  = 12;

    // csr access opcodes, same encoding as funct3 of csrrw/csrrs/csrrc
    typedef enum logic [1:0] {
        CSR_RW = 2'd1,
        CSR_RS = 2'd2,
        CSR_RC = 2'd3
    } csr_op_e;

    // machine csr addresses
    localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIE     = 12'h304;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC   = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC    = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE  = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIP     = 12'h344;

    // ========================================================================
    // interrupt controller register map
    // ========================================================================
    // priority of source n at PLIC_PRIO_BASE + 4n
    localparam logic [PLIC_ADDR_W-1:0] PLIC_PRIO_BASE = 24'h000000;
    localparam logic [PLIC_ADDR_W-1:0] PLIC_PENDING   = 24'h001000;
    localparam logic [PLIC_ADDR_W-1:0] PLIC_ENABLE    = 24'h002000;
    localparam logic [PLIC_ADDR_W-1:0] PLIC_THRESHOLD = 24'h200000;
    localparam logic [PLIC_ADDR_W-1:0] PLIC_CLAIM     = 24'h200004;

    // interrupt numbers, also bit positions in mie and mip
    localparam logic [4:0] IRQ_MSI = 5'd3;
    localparam logic [4:0] IRQ_MTI = 5'd7;
    localparam logic [4:0] IRQ_MEI = 5'd11;

    // mstatus fields kept by this core
    localparam logic [4:0] MSTATUS_MIE  = 5'd3;
    localparam logic [4:0] MSTATUS_MPIE = 5'd7;

    typedef enum logic {
        TRAP_IDLE,
        TRAP_REDIRECT
    } trap_state_e;

endpackage

// File: hdl/plic_arbiter.sv
`timescale 1ns/1ps

module plic_arbiter import mcu_trap_pkg::*; #(
    parameter int NUM_SOURCES = 32,
    parameter int PRIO_W      = 3
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic [NUM_SOURCES-1:0] irq_sources_i,
    input  logic                   bus_wen_i,
    input  logic                   bus_ren_i,
    input  logic [PLIC_ADDR_W-1:0] bus_addr_i,
    input  logic [XLEN-1:0]        bus_wdata_i,
    output logic [XLEN-1:0]        bus_rdata_o,
    output logic                   meip_o
);

    localparam int ID_W = $clog2(NUM_SOURCES);
    // source 0 is reserved and never pends
    localparam logic [NUM_SOURCES-1:0] SRC_MASK = ~NUM_SOURCES'(1);

    logic [NUM_SOURCES-1:0] pending_q;
    logic [NUM_SOURCES-1:0] in_service_q;
    logic [NUM_SOURCES-1:0] enable_q;
    logic [PRIO_W-1:0]      prio_q [NUM_SOURCES];
    logic [PRIO_W-1:0]      threshold_q;

    logic [ID_W-1:0]        best_id;
    logic [PRIO_W-1:0]      best_prio;
    logic [ID_W-1:0]        claim_id;
    logic                   claim_rd;
    logic                   complete_wr;
    logic [NUM_SOURCES-1:0] claim_mask;
    logic [NUM_SOURCES-1:0] complete_mask;
    logic [PLIC_ADDR_W-1:0] prio_off;
    logic                   prio_hit;
    logic [ID_W-1:0]        prio_idx;
    logic [XLEN-1:0]        rdata_d;

    // ========================================================================
    // arbitration
    // ========================================================================
    // strict compare while scanning upward, so ties stay with the lowest id
    always_comb begin
        best_id   = '0;
        best_prio = '0;
        for (int i = 1; i < NUM_SOURCES; i++) begin
            if (pending_q[i] && enable_q[i] && prio_q[i] > best_prio) begin
                best_id   = ID_W'(i);
                best_prio = prio_q[i];
            end
        end
    end

    assign meip_o   = best_prio > threshold_q;
    assign claim_id = meip_o ? best_id : '0;

    assign claim_rd      = bus_ren_i && (bus_addr_i == PLIC_CLAIM);
    assign complete_wr   = bus_wen_i && (bus_addr_i == PLIC_CLAIM);
    assign claim_mask    = claim_rd ? (NUM_SOURCES'(1) << claim_id) : '0;
    assign complete_mask = (complete_wr && bus_wdata_i < NUM_SOURCES) ?
                           (NUM_SOURCES'(1) << bus_wdata_i[ID_W-1:0]) : '0;

    // ========================================================================
    // register access
    // ========================================================================
    assign prio_off = bus_addr_i - PLIC_PRIO_BASE;
    assign prio_hit = (prio_off[1:0] == 2'b00) && ((prio_off >> 2) < NUM_SOURCES);
    assign prio_idx = prio_off[ID_W+1:2];

    always_comb begin
        rdata_d = '0;
        if (bus_addr_i == PLIC_CLAIM) begin
            rdata_d = XLEN'(claim_id);
        end else if (bus_addr_i == PLIC_THRESHOLD) begin
            rdata_d = XLEN'(threshold_q);
        end else if (prio_hit) begin
            rdata_d = XLEN'(prio_q[prio_idx]);
        end else begin
            // pending and enable are packed XLEN sources per word
            for (int i = 0; i < NUM_SOURCES; i++) begin
                if (bus_addr_i == PLIC_PENDING + PLIC_ADDR_W'(4 * (i / XLEN))) begin
                    rdata_d[i % XLEN] = pending_q[i];
                end
                if (bus_addr_i == PLIC_ENABLE + PLIC_ADDR_W'(4 * (i / XLEN))) begin
                    rdata_d[i % XLEN] = enable_q[i];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pending_q    <= '0;
            in_service_q <= '0;
            enable_q     <= '0;
            threshold_q  <= '0;
            bus_rdata_o  <= '0;
            for (int i = 0; i < NUM_SOURCES; i++) begin
                prio_q[i] <= '0;
            end
        end else begin
            // claim wins over a new request of the same source
            pending_q    <= (pending_q | (irq_sources_i & ~in_service_q)) & ~claim_mask
                            & SRC_MASK;
            in_service_q <= (in_service_q | claim_mask) & ~complete_mask & SRC_MASK;
            if (bus_ren_i) begin
                bus_rdata_o <= rdata_d;
            end
            if (bus_wen_i) begin
                if (bus_addr_i == PLIC_THRESHOLD) begin
                    threshold_q <= bus_wdata_i[PRIO_W-1:0];
                end
                if (prio_hit && prio_idx != '0) begin
                    prio_q[prio_idx] <= bus_wdata_i[PRIO_W-1:0];
                end
                for (int i = 1; i < NUM_SOURCES; i++) begin
                    if (bus_addr_i == PLIC_ENABLE + PLIC_ADDR_W'(4 * (i / XLEN))) begin
                        enable_q[i] <= bus_wdata_i[i % XLEN];
                    end
                end
            end
        end
    end

    a_claim_not_in_service: assert property (@(posedge clk) disable iff (!resetn)
        claim_rd && claim_id != '0 |-> !in_service_q[claim_id]);

endmodule

// File: hdl/csr_file.sv
`timescale 1ns/1ps

module csr_file import mcu_trap_pkg::*; (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  csr_en_i,
    input  csr_op_e               csr_op_i,
    input  logic [CSR_ADDR_W-1:0] csr_addr_i,
    input  logic [XLEN-1:0]       csr_wdata_i,
    input  logic [XLEN-1:0]       mip_i,
    input  logic                  trap_take_i,
    input  logic [XLEN-1:0]       trap_cause_i,
    input  logic [XLEN-1:0]       trap_epc_i,
    input  logic                  mret_take_i,
    output logic [XLEN-1:0]       csr_rdata_o,
    output logic                  mstatus_mie_o,
    output logic [XLEN-1:0]       mie_o,
    output logic [XLEN-1:0]       mtvec_o,
    output logic [XLEN-1:0]       mepc_o
);

    localparam logic [XLEN-1:0] MSTATUS_MASK = (XLEN'(1) << MSTATUS_MIE)
                                             | (XLEN'(1) << MSTATUS_MPIE);
    localparam logic [XLEN-1:0] MIE_MASK = (XLEN'(1) << IRQ_MSI)
                                         | (XLEN'(1) << IRQ_MTI)
                                         | (XLEN'(1) << IRQ_MEI);

    logic [XLEN-1:0] mstatus_q;
    logic [XLEN-1:0] mie_q;
    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] mcause_q;
    logic [XLEN-1:0] old_val;
    logic [XLEN-1:0] new_val;

    always_comb begin
        case (csr_addr_i)
            CSR_MSTATUS: old_val = mstatus_q;
            CSR_MIE:     old_val = mie_q;
            CSR_MTVEC:   old_val = mtvec_q;
            CSR_MEPC:    old_val = mepc_q;
            CSR_MCAUSE:  old_val = mcause_q;
            CSR_MIP:     old_val = mip_i;
            default:     old_val = '0;
        endcase
    end

    // read-modify-write value before the per-register masks
    always_comb begin
        case (csr_op_i)
            CSR_RW:  new_val = csr_wdata_i;
            CSR_RS:  new_val = old_val | csr_wdata_i;
            CSR_RC:  new_val = old_val & ~csr_wdata_i;
            default: new_val = old_val;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mstatus_q   <= '0;
            mie_q       <= '0;
            mtvec_q     <= '0;
            mepc_q      <= '0;
            mcause_q    <= '0;
            csr_rdata_o <= '0;
        end else begin
            if (csr_en_i) begin
                csr_rdata_o <= old_val;
            end
            if (csr_en_i && csr_addr_i == CSR_MIE) begin
                mie_q <= new_val & MIE_MASK;
            end
            if (csr_en_i && csr_addr_i == CSR_MTVEC) begin
                mtvec_q <= {new_val[XLEN-1:2], 1'b0, new_val[0]};
            end
            // trap and mret take precedence over a software write
            if (trap_take_i) begin
                mstatus_q[MSTATUS_MPIE] <= mstatus_q[MSTATUS_MIE];
                mstatus_q[MSTATUS_MIE]  <= 1'b0;
                mepc_q                  <= trap_epc_i;
                mcause_q                <= trap_cause_i;
            end else if (mret_take_i) begin
                mstatus_q[MSTATUS_MIE]  <= mstatus_q[MSTATUS_MPIE];
                mstatus_q[MSTATUS_MPIE] <= 1'b1;
            end else if (csr_en_i) begin
                case (csr_addr_i)
                    CSR_MSTATUS: mstatus_q <= new_val & MSTATUS_MASK;
                    CSR_MEPC:    mepc_q    <= {new_val[XLEN-1:1], 1'b0};
                    CSR_MCAUSE:  mcause_q  <= new_val;
                    default:     mcause_q  <= mcause_q;
                endcase
            end
        end
    end

    assign mstatus_mie_o = mstatus_q[MSTATUS_MIE];
    assign mie_o         = mie_q;
    assign mtvec_o       = mtvec_q;
    assign mepc_o        = mepc_q;

    a_take_exclusive: assert property (@(posedge clk) disable iff (!resetn)
        !(trap_take_i && mret_take_i));

endmodule

// File: hdl/trap_controller.sv
`timescale 1ns/1ps

module trap_controller import mcu_trap_pkg::*; (
    input  logic            clk,
    input  logic            resetn,
    input  logic            meip_i,
    input  logic            msip_i,
    input  logic            mtip_i,
    input  logic            mstatus_mie_i,
    input  logic [XLEN-1:0] mie_i,
    input  logic [XLEN-1:0] mtvec_i,
    input  logic [XLEN-1:0] mepc_i,
    input  logic            mret_i,
    input  logic [XLEN-1:0] retire_pc_i,
    output logic [XLEN-1:0] mip_o,
    output logic            trap_take_o,
    output logic [XLEN-1:0] trap_cause_o,
    output logic [XLEN-1:0] trap_epc_o,
    output logic            mret_take_o,
    output logic            redirect_o,
    output logic [XLEN-1:0] redirect_pc_o,
    output logic [XLEN-1:0] redirect_cause_o
);

    trap_state_e     state_q;
    logic [XLEN-1:0] pend;
    logic [4:0]      irq_num;
    logic            irq_valid;
    logic            idle;
    logic [XLEN-1:0] vec_base;
    logic [XLEN-1:0] trap_target;

    always_comb begin
        mip_o          = '0;
        mip_o[IRQ_MEI] = meip_i;
        mip_o[IRQ_MSI] = msip_i;
        mip_o[IRQ_MTI] = mtip_i;
    end

    // fixed order MEI, MSI, MTI
    assign pend      = mip_o & mie_i;
    assign irq_valid = pend[IRQ_MEI] | pend[IRQ_MSI] | pend[IRQ_MTI];
    assign irq_num   = pend[IRQ_MEI] ? IRQ_MEI : (pend[IRQ_MSI] ? IRQ_MSI : IRQ_MTI);

    // no new take while the redirect is in flight, mret beats an interrupt
    assign idle         = (state_q == TRAP_IDLE);
    assign mret_take_o  = idle && mret_i;
    assign trap_take_o  = idle && !mret_i && irq_valid && mstatus_mie_i;
    assign trap_cause_o = {1'b1, {(XLEN-6){1'b0}}, irq_num};
    assign trap_epc_o   = retire_pc_i;

    assign vec_base    = {mtvec_i[XLEN-1:2], 2'b00};
    assign trap_target = mtvec_i[0] ? vec_base + {{(XLEN-7){1'b0}}, irq_num, 2'b00} : vec_base;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q <= TRAP_IDLE;
        end else begin
            case (state_q)
                TRAP_IDLE:     state_q <= (trap_take_o || mret_take_o) ? TRAP_REDIRECT
                                                                        : TRAP_IDLE;
                TRAP_REDIRECT: state_q <= TRAP_IDLE;
                default:       state_q <= TRAP_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mret_take_o) begin
            redirect_pc_o    <= mepc_i;
            redirect_cause_o <= '0;
        end else if (trap_take_o) begin
            redirect_pc_o    <= trap_target;
            redirect_cause_o <= trap_cause_o;
        end
    end

    assign redirect_o = (state_q == TRAP_REDIRECT);

    a_trap_clears_mie: assert property (@(posedge clk) disable iff (!resetn)
        trap_take_o |=> !mstatus_mie_i);

endmodule

// File: hdl/mcu_trap_unit.sv
`timescale 1ns/1ps

module mcu_trap_unit import mcu_trap_pkg::*; #(
    parameter int NUM_SOURCES = 32,
    parameter int PRIO_W      = 3
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic [NUM_SOURCES-1:0] irq_sources_i,
    input  logic                   msip_i,
    input  logic                   mtip_i,
    // interrupt controller bus
    input  logic                   plic_wen_i,
    input  logic                   plic_ren_i,
    input  logic [PLIC_ADDR_W-1:0] plic_addr_i,
    input  logic [XLEN-1:0]        plic_wdata_i,
    output logic [XLEN-1:0]        plic_rdata_o,
    // csr access
    input  logic                   csr_en_i,
    input  csr_op_e                csr_op_i,
    input  logic [CSR_ADDR_W-1:0]  csr_addr_i,
    input  logic [XLEN-1:0]        csr_wdata_i,
    output logic [XLEN-1:0]        csr_rdata_o,
    // commit side
    input  logic                   mret_i,
    input  logic [XLEN-1:0]        retire_pc_i,
    output logic                   redirect_o,
    output logic [XLEN-1:0]        redirect_pc_o,
    output logic [XLEN-1:0]        redirect_cause_o
);

    logic            meip;
    logic            mstatus_mie;
    logic [XLEN-1:0] mie;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mip;
    logic            trap_take;
    logic [XLEN-1:0] trap_cause;
    logic [XLEN-1:0] trap_epc;
    logic            mret_take;

    plic_arbiter #(
        .NUM_SOURCES (NUM_SOURCES),
        .PRIO_W      (PRIO_W)
    ) u_plic_arbiter (
        .clk           (clk),
        .resetn        (resetn),
        .irq_sources_i (irq_sources_i),
        .bus_wen_i     (plic_wen_i),
        .bus_ren_i     (plic_ren_i),
        .bus_addr_i    (plic_addr_i),
        .bus_wdata_i   (plic_wdata_i),
        .bus_rdata_o   (plic_rdata_o),
        .meip_o        (meip)
    );

    csr_file u_csr_file (
        .clk           (clk),
        .resetn        (resetn),
        .csr_en_i      (csr_en_i),
        .csr_op_i      (csr_op_i),
        .csr_addr_i    (csr_addr_i),
        .csr_wdata_i   (csr_wdata_i),
        .mip_i         (mip),
        .trap_take_i   (trap_take),
        .trap_cause_i  (trap_cause),
        .trap_epc_i    (trap_epc),
        .mret_take_i   (mret_take),
        .csr_rdata_o   (csr_rdata_o),
        .mstatus_mie_o (mstatus_mie),
        .mie_o         (mie),
        .mtvec_o       (mtvec),
        .mepc_o        (mepc)
    );

    trap_controller u_trap_controller (
        .clk              (clk),
        .resetn           (resetn),
        .meip_i           (meip),
        .msip_i           (msip_i),
        .mtip_i           (mtip_i),
        .mstatus_mie_i    (mstatus_mie),
        .mie_i            (mie),
        .mtvec_i          (mtvec),
        .mepc_i           (mepc),
        .mret_i           (mret_i),
        .retire_pc_i      (retire_pc_i),
        .mip_o            (mip),
        .trap_take_o      (trap_take),
        .trap_cause_o     (trap_cause),
        .trap_epc_o       (trap_epc),
        .mret_take_o      (mret_take),
        .redirect_o       (redirect_o),
        .redirect_pc_o    (redirect_pc_o),
        .redirect_cause_o (redirect_cause_o)
    );

endmodule

// File: verification/tb_mcu_trap_unit.sv
`timescale 1ns/1ps

module tb_mcu_trap_unit import mcu_trap_pkg::*; ();

    localparam int          NUM_SOURCES = 32;
    localparam int          PRIO_W      = 3;
    localparam int          CLK_PERIOD  = 40;
    localparam int          NUM_TESTS   = 5;
    localparam logic [31:0] SEED        = 32'h0aee_d532;

    logic                   clk;
    logic                   resetn;
    logic [NUM_SOURCES-1:0] irq_sources;
    logic                   msip;
    logic                   mtip;
    logic                   plic_wen;
    logic                   plic_ren;
    logic [PLIC_ADDR_W-1:0] plic_addr;
    logic [XLEN-1:0]        plic_wdata;
    logic [XLEN-1:0]        plic_rdata;
    logic                   csr_en;
    csr_op_e                csr_op;
    logic [CSR_ADDR_W-1:0]  csr_addr;
    logic [XLEN-1:0]        csr_wdata;
    logic [XLEN-1:0]        csr_rdata;
    logic                   mret;
    logic [XLEN-1:0]        retire_pc;
    logic                   redirect;
    logic [XLEN-1:0]        redirect_pc;
    logic [XLEN-1:0]        redirect_cause;

    // testbench copies of the interrupt controller state
    logic [PRIO_W-1:0]      tb_prio [NUM_SOURCES];
    logic [NUM_SOURCES-1:0] tb_enable;
    logic [PRIO_W-1:0]      tb_threshold;
    logic [NUM_SOURCES-1:0] tb_src;
    logic [NUM_SOURCES-1:0] tb_pend;
    logic [NUM_SOURCES-1:0] tb_in_service;

    // shadow csrs
    logic [XLEN-1:0] sh_mstatus;
    logic [XLEN-1:0] sh_mie;
    logic [XLEN-1:0] sh_mtvec;
    logic [XLEN-1:0] sh_mepc;
    logic [XLEN-1:0] sh_mcause;

    // expected redirect, armed by the stimulus and cleared by the monitor
    logic            exp_armed;
    logic [XLEN-1:0] exp_pc;
    logic [XLEN-1:0] exp_cause;

    mcu_trap_unit #(
        .NUM_SOURCES (NUM_SOURCES),
        .PRIO_W      (PRIO_W)
    ) dut0 (
        .clk              (clk),
        .resetn           (resetn),
        .irq_sources_i    (irq_sources),
        .msip_i           (msip),
        .mtip_i           (mtip),
        .plic_wen_i       (plic_wen),
        .plic_ren_i       (plic_ren),
        .plic_addr_i      (plic_addr),
        .plic_wdata_i     (plic_wdata),
        .plic_rdata_o     (plic_rdata),
        .csr_en_i         (csr_en),
        .csr_op_i         (csr_op),
        .csr_addr_i       (csr_addr),
        .csr_wdata_i      (csr_wdata),
        .csr_rdata_o      (csr_rdata),
        .mret_i           (mret),
        .retire_pc_i      (retire_pc),
        .redirect_o       (redirect),
        .redirect_pc_o    (redirect_pc),
        .redirect_cause_o (redirect_cause)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        fail_run("timeout, the tests did not finish within the time limit");
    end

    // ========================================================================
    // compare tasks and reference models
    // ========================================================================
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_claim(input string name, input logic [NUM_SOURCES-1:0] got,
                               input logic [NUM_SOURCES-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_redirect(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] cause,
                                  input logic [XLEN-1:0] want_pc,
                                  input logic [XLEN-1:0] want_cause);
        check_word("redirect_pc_o", pc, want_pc);
        check_word("redirect_cause_o", cause, want_cause);
    endtask

    // highest priority wins, ties to the lowest id, cut by the threshold
    function automatic logic [NUM_SOURCES-1:0] expected_claim();
        int best;
        int best_p;
        best   = 0;
        best_p = 0;
        for (int i = 1; i < NUM_SOURCES; i++) begin
            if (tb_pend[i] && tb_enable[i] && tb_prio[i] > best_p) begin
                best   = i;
                best_p = tb_prio[i];
            end
        end
        return (best_p > tb_threshold) ? NUM_SOURCES'(best) : '0;
    endfunction

    function automatic logic [XLEN-1:0] shadow_read(input logic [CSR_ADDR_W-1:0] addr);
        case (addr)
            CSR_MSTATUS: return sh_mstatus;
            CSR_MIE:     return sh_mie;
            CSR_MTVEC:   return sh_mtvec;
            CSR_MEPC:    return sh_mepc;
            CSR_MCAUSE:  return sh_mcause;
            CSR_MIP:     return (XLEN'(msip) << 3) | (XLEN'(mtip) << 7);
            default:     return '0;
        endcase
    endfunction

    function automatic void shadow_write(input logic [CSR_ADDR_W-1:0] addr,
                                         input logic [XLEN-1:0] v);
        case (addr)
            CSR_MSTATUS: sh_mstatus = v & 32'h0000_0088;
            CSR_MIE:     sh_mie     = v & 32'h0000_0888;
            CSR_MTVEC:   sh_mtvec   = v & ~32'h2;
            CSR_MEPC:    sh_mepc    = v & ~32'h1;
            CSR_MCAUSE:  sh_mcause  = v;
            default:     ;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] irq_target(input logic [4:0] num);
        logic [XLEN-1:0] base;
        base = sh_mtvec & ~32'h3;
        return sh_mtvec[0] ? base + 4 * num : base;
    endfunction

    // comparing process for the redirect port
    always @(negedge clk) begin
        if (resetn && redirect !== 1'b0) begin
            if (!exp_armed) begin
                fail_run("redirect pulse seen while no trap or mret was expected");
            end else begin
                check_redirect(redirect_pc, redirect_cause, exp_pc, exp_cause);
                exp_armed = 1'b0;
            end
        end
    end

    // ========================================================================
    // bus tasks
    // ========================================================================
    task automatic csr_access(input csr_op_e op, input logic [CSR_ADDR_W-1:0] addr,
                              input logic [XLEN-1:0] wdata);
        logic [XLEN-1:0] old_v;
        logic [XLEN-1:0] new_v;
        old_v = shadow_read(addr);
        case (op)
            CSR_RS:  new_v = old_v | wdata;
            CSR_RC:  new_v = old_v & ~wdata;
            default: new_v = wdata;
        endcase
        csr_en    = 1'b1;
        csr_op    = op;
        csr_addr  = addr;
        csr_wdata = wdata;
        @(negedge clk);
        csr_en = 1'b0;
        check_word($sformatf("csr_rdata_o at 0x%03h", addr), csr_rdata, old_v);
        shadow_write(addr, new_v);
    endtask

    task automatic plic_write(input logic [PLIC_ADDR_W-1:0] addr, input logic [XLEN-1:0] data);
        plic_wen   = 1'b1;
        plic_addr  = addr;
        plic_wdata = data;
        @(negedge clk);
        plic_wen = 1'b0;
    endtask

    task automatic plic_read(input logic [PLIC_ADDR_W-1:0] addr, output logic [XLEN-1:0] data);
        plic_ren  = 1'b1;
        plic_addr = addr;
        @(negedge clk);
        plic_ren = 1'b0;
        data     = plic_rdata;
    endtask

    task automatic wait_redirect(input string what);
        int cycles;
        cycles = 0;
        while (exp_armed && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_armed) begin
            fail_run({what, " did not arrive within 20 cycles"});
        end
        @(negedge clk);
    endtask

    // set MIE, expect the trap, then read back the trap csrs
    task automatic take_irq(input logic [4:0] num);
        exp_pc    = irq_target(num);
        exp_cause = {1'b1, 26'b0, num};
        exp_armed = 1'b1;
        csr_access(CSR_RS, CSR_MSTATUS, 32'h8);
        wait_redirect($sformatf("trap redirect for interrupt %0d", num));
        sh_mepc    = retire_pc;
        sh_mcause  = exp_cause;
        sh_mstatus = 32'h0000_0080;
        csr_access(CSR_RS, CSR_MEPC, '0);
        csr_access(CSR_RS, CSR_MCAUSE, '0);
        csr_access(CSR_RS, CSR_MSTATUS, '0);
    endtask

    task automatic do_mret(input logic raise_msi);
        exp_pc    = sh_mepc;
        exp_cause = '0;
        exp_armed = 1'b1;
        mret      = 1'b1;
        msip      = raise_msi;
        @(negedge clk);
        mret = 1'b0;
        @(posedge clk);
        if (exp_armed) begin
            fail_run("mret redirect was not seen one cycle after mret");
        end
        sh_mstatus = sh_mstatus[7] ? 32'h0000_0088 : 32'h0000_0080;
    endtask

    task automatic raise_ext(input int k);
        plic_write(PLIC_PRIO_BASE + PLIC_ADDR_W'(4 * k), 32'd7);
        plic_write(PLIC_THRESHOLD, 32'd0);
        plic_write(PLIC_ENABLE, 32'd1 << k);
        irq_sources[k] = 1'b1;
    endtask

    task automatic drop_ext(input int k);
        logic [XLEN-1:0] word;
        plic_read(PLIC_CLAIM, word);
        check_claim("claim id", word[NUM_SOURCES-1:0], NUM_SOURCES'(k));
        irq_sources[k] = 1'b0;
        plic_write(PLIC_CLAIM, XLEN'(k));
    endtask

    // ========================================================================
    // tests
    // ========================================================================
    task automatic test_csr();
        logic [CSR_ADDR_W-1:0] addrs [5];
        addrs = '{CSR_MSTATUS, CSR_MIE, CSR_MTVEC, CSR_MEPC, CSR_MCAUSE};
        repeat (3) begin
            foreach (addrs[a]) begin
                csr_access(CSR_RW, addrs[a], $urandom);
                csr_access(CSR_RS, addrs[a], $urandom);
                csr_access(CSR_RC, addrs[a], $urandom);
            end
        end
        csr_access(CSR_RW, CSR_MSTATUS, '0);
        msip = 1'b1;
        csr_access(CSR_RW, CSR_MIP, $urandom);
        csr_access(CSR_RS, CSR_MIP, '0);
        msip = 1'b0;
        csr_access(CSR_RW, 12'h7c0, $urandom);
        csr_access(CSR_RS, 12'h7c0, '0);
    endtask

    task automatic test_plic();
        logic [XLEN-1:0]        word;
        logic [NUM_SOURCES-1:0] exp_id;
        for (int i = 1; i < NUM_SOURCES; i++) begin
            tb_prio[i] = PRIO_W'($urandom_range(7, 0));
            plic_write(PLIC_PRIO_BASE + PLIC_ADDR_W'(4 * i), XLEN'(tb_prio[i]));
        end
        for (int i = 1; i < NUM_SOURCES; i++) begin
            plic_read(PLIC_PRIO_BASE + PLIC_ADDR_W'(4 * i), word);
            check_word($sformatf("priority %0d", i), word, XLEN'(tb_prio[i]));
        end
        tb_enable    = $urandom & ~32'h1;
        tb_threshold = PRIO_W'($urandom_range(3, 0));
        plic_write(PLIC_ENABLE, tb_enable);
        plic_write(PLIC_THRESHOLD, XLEN'(tb_threshold));
        plic_read(PLIC_ENABLE, word);
        check_word("enable", word, tb_enable);
        plic_read(PLIC_THRESHOLD, word);
        check_word("threshold", word, XLEN'(tb_threshold));
        tb_src      = $urandom;
        irq_sources = tb_src;
        @(negedge clk);
        tb_pend = tb_src & ~32'h1;
        // drain every claimable source, each only once
        repeat (NUM_SOURCES) begin
            exp_id = expected_claim();
            plic_read(PLIC_CLAIM, word);
            check_claim("claim id", word[NUM_SOURCES-1:0], exp_id);
            tb_pend[exp_id]       = 1'b0;
            tb_in_service[exp_id] = exp_id != '0;
        end
        for (int i = 1; i < NUM_SOURCES; i++) begin
            if (tb_in_service[i]) begin
                plic_write(PLIC_CLAIM, XLEN'(i));
            end
        end
        tb_in_service = '0;
        @(negedge clk);
        tb_pend = tb_pend | (tb_src & ~32'h1);
        plic_write(PLIC_PENDING, $urandom);
        plic_read(PLIC_PENDING, word);
        check_word("pending", word, tb_pend);
        exp_id = expected_claim();
        plic_read(PLIC_CLAIM, word);
        check_claim("claim id after complete", word[NUM_SOURCES-1:0], exp_id);
        irq_sources = '0;
        plic_write(PLIC_ENABLE, '0);
        plic_write(PLIC_CLAIM, XLEN'(exp_id));
    endtask

    task automatic test_ext();
        int k;
        k         = $urandom_range(NUM_SOURCES - 1, 1);
        retire_pc = $urandom & ~32'h3;
        csr_access(CSR_RW, CSR_MIE, 32'h800);
        // direct mode first, then vectored
        for (int mode = 0; mode < 2; mode++) begin
            csr_access(CSR_RW, CSR_MTVEC, ($urandom & ~32'h3) | XLEN'(mode));
            raise_ext(k);
            take_irq(IRQ_MEI);
            drop_ext(k);
        end
    endtask

    task automatic test_priority();
        int k;
        k = $urandom_range(NUM_SOURCES - 1, 1);
        csr_access(CSR_RW, CSR_MIE, 32'h888);
        msip = 1'b1;
        mtip = 1'b1;
        raise_ext(k);
        repeat (6) @(negedge clk);
        take_irq(IRQ_MEI);
        drop_ext(k);
        take_irq(IRQ_MSI);
        msip = 1'b0;
        take_irq(IRQ_MTI);
        mtip = 1'b0;
        // mie bit clear keeps a pending software interrupt quiet
        msip = 1'b1;
        csr_access(CSR_RW, CSR_MIE, 32'h080);
        csr_access(CSR_RS, CSR_MSTATUS, 32'h8);
        repeat (6) @(negedge clk);
        msip = 1'b0;
        csr_access(CSR_RC, CSR_MSTATUS, 32'h8);
    endtask

    task automatic test_mret();
        csr_access(CSR_RW, CSR_MEPC, $urandom);
        csr_access(CSR_RW, CSR_MSTATUS, 32'h80);
        do_mret(1'b0);
        @(negedge clk);
        csr_access(CSR_RS, CSR_MSTATUS, '0);
        // mret and an eligible interrupt at the same edge
        csr_access(CSR_RW, CSR_MIE, 32'h008);
        do_mret(1'b1);
        exp_pc    = irq_target(IRQ_MSI);
        exp_cause = {1'b1, 26'b0, IRQ_MSI};
        exp_armed = 1'b1;
        wait_redirect("interrupt after mret");
        msip       = 1'b0;
        sh_mepc    = retire_pc;
        sh_mcause  = exp_cause;
        sh_mstatus = 32'h0000_0080;
        csr_access(CSR_RS, CSR_MEPC, '0);
        csr_access(CSR_RS, CSR_MSTATUS, '0);
    endtask

    initial begin
        void'($urandom(SEED));
        resetn      = 1'b0;
        irq_sources = '0;
        msip        = 1'b0;
        mtip        = 1'b0;
        plic_wen    = 1'b0;
        plic_ren    = 1'b0;
        plic_addr   = '0;
        plic_wdata  = '0;
        csr_en      = 1'b0;
        csr_op      = CSR_RW;
        csr_addr    = '0;
        csr_wdata   = '0;
        mret        = 1'b0;
        retire_pc   = '0;
        exp_armed   = 1'b0;
        exp_pc      = '0;
        exp_cause   = '0;
        tb_enable     = '0;
        tb_threshold  = '0;
        tb_src        = '0;
        tb_pend       = '0;
        tb_in_service = '0;
        foreach (tb_prio[i]) begin
            tb_prio[i] = '0;
        end
        sh_mstatus = '0;
        sh_mie     = '0;
        sh_mtvec   = '0;
        sh_mepc    = '0;
        sh_mcause  = '0;
        repeat (16) @(negedge clk);
        resetn = 1'b1;
        check_word("plic_rdata_o", plic_rdata, '0);
        check_word("csr_rdata_o", csr_rdata, '0);
        test_csr();
        test_plic();
        test_ext();
        test_priority();
        test_mret();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: mcu_trap_unit.f
hdl/mcu_trap_pkg.sv
hdl/plic_arbiter.sv
hdl/csr_file.sv
hdl/trap_controller.sv
hdl/mcu_trap_unit.sv
verification/tb_mcu_trap_unit.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_mcu_trap_unit \
    -f mcu_trap_unit.f \
    && ./obj_dir/Vtb_mcu_trap_unit | tee /dev/stderr | grep -q "STATUS: PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
